// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory exerciser testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=mem_exercise_tb
LOG=sim.log

verilator --binary --assert --timing -Wno-fatal --timescale 1ns/1ps \
	--top-module "$TOP" -f vlog.f > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/V$TOP +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0

// ==== src/line_store.sv ====
`timescale 1ns/1ps
`include "memx_params.svh"

module line_store #(
	parameter int LATENCY = `MEMX_LATENCY
)
(
	input logic clk,
	input logic rst,
	input logic cmd_valid,
	input memx_pkg::mem_cmd_t cmd,
	output memx_pkg::mem_rsp_t rsp
);

	localparam int LINE_BITS = `MEMX_LINE_BITS;
	localparam int DEPTH = `MEMX_STORE_DEPTH;
	localparam int IDX_BITS = $clog2(DEPTH);
	localparam int CNT_BITS = (LATENCY > 1) ? $clog2(LATENCY) : 1;

	logic [LINE_BITS-1:0] mem [0:DEPTH-1];

	logic active;
	logic [CNT_BITS-1:0] count;
	logic [CNT_BITS-1:0] elapsed;
	logic new_cmd;
	logic fire;
	logic [IDX_BITS-1:0] idx;

	logic ready_q;
	logic [LINE_BITS-1:0] rd_data_q;

	// Line index from the address, above the 8-byte step
	assign idx = cmd.addr[IDX_BITS+2:3];

	////////////////////
	// Latency counter
	////////////////////

	// Still high in the ready cycle, so that cycle is not a new command
	assign new_cmd = cmd_valid && !active && !ready_q;
	assign elapsed = active ? count : '0;
	assign fire = (new_cmd || active) && (elapsed == CNT_BITS'(LATENCY - 1));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			active <= 1'b0;
			count <= '0;
			ready_q <= 1'b0;
		end
		else
		begin
			ready_q <= fire;
			if (fire)
			begin
				active <= 1'b0;
				count <= '0;
			end
			else if (new_cmd)
			begin
				active <= 1'b1;
				count <= CNT_BITS'(1);
			end
			else if (active)
			begin
				count <= count + 1'b1;
			end
		end
	end

	////////////////////
	// Line memory
	////////////////////

	always_ff @(posedge clk)
	begin
		if (fire)
		begin
			if (cmd.write)
			begin
				mem[idx] <= cmd.data;
			end
			else
			begin
				rd_data_q <= mem[idx];
			end
		end
	end

	assign rsp = '{ready: ready_q, data: rd_data_q};

endmodule

// ==== src/mem_exercise_top.sv ====
`timescale 1ns/1ps
`include "memx_params.svh"

module mem_exercise_top
(
	input logic clk,
	input logic rst,
	input logic start,
	input memx_pkg::test_mode_e mode,
	input logic [31:0] seed,
	output logic busy,
	output logic done,
	output logic [15:0] mismatch_count,
	output logic [`MEMX_ADDR_BITS-1:0] first_bad_addr,
	output logic any_mismatch
);

	logic cmd_valid;
	memx_pkg::mem_cmd_t cmd;
	memx_pkg::mem_rsp_t rsp;
	logic pass_start;

	// Command source
	pattern_sequencer u_seq
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.mode(mode),
		.seed(seed),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.rsp(rsp),
		.busy(busy),
		.done(done),
		.pass_start(pass_start)
	);

	// Stand-in for the DDR2 controller and memory
	line_store #(.LATENCY(`MEMX_LATENCY)) u_store
	(
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.rsp(rsp)
	);

	readback_checker u_chk
	(
		.clk(clk),
		.rst(rst),
		.pass_start(pass_start),
		.cmd(cmd),
		.rsp(rsp),
		.mismatch_count(mismatch_count),
		.first_bad_addr(first_bad_addr),
		.any_mismatch(any_mismatch)
	);

endmodule

// ==== src/memx_params.svh ====
`ifndef MEMX_PARAMS_SVH
`define MEMX_PARAMS_SVH

// Line and address widths
`define MEMX_LINE_BITS 256
`define MEMX_ADDR_BITS 28

// Pass geometry
`define MEMX_NUM_LINES 9
`define MEMX_BASE_ADDR 28'h0001000
`define MEMX_ADDR_STRIDE 8

// Cycles from command accept to ready
`define MEMX_LATENCY 3

// Store entries, indexed by address bits 6 down to 3
`define MEMX_STORE_DEPTH 16

`endif

// ==== src/memx_pkg.sv ====
`include "memx_params.svh"

package memx_pkg;

	////////////////////
	// Test modes
	////////////////////

	typedef enum logic [1:0]
	{
		MODE_WRITE_READ = 2'd0,
		MODE_WRITE_ONLY = 2'd1,
		MODE_READ_ONLY = 2'd2
	} test_mode_e;

	////////////////////
	// Command channel
	////////////////////

	// On a read, data holds the expected line
	typedef struct packed
	{
		logic write;
		logic [`MEMX_ADDR_BITS-1:0] addr;
		logic [`MEMX_LINE_BITS-1:0] data;
	} mem_cmd_t;

	// Ready is a one-cycle pulse per command
	typedef struct packed
	{
		logic ready;
		logic [`MEMX_LINE_BITS-1:0] data;
	} mem_rsp_t;

endpackage

// ==== src/pattern_sequencer.sv ====
`timescale 1ns/1ps
`include "memx_params.svh"

module pattern_sequencer
(
	input logic clk,
	input logic rst,
	input logic start,
	input memx_pkg::test_mode_e mode,
	input logic [31:0] seed,
	output logic cmd_valid,
	output memx_pkg::mem_cmd_t cmd,
	input memx_pkg::mem_rsp_t rsp,
	output logic busy,
	output logic done,
	output logic pass_start
);

	localparam int LINE_BITS = `MEMX_LINE_BITS;
	localparam int ADDR_BITS = `MEMX_ADDR_BITS;
	localparam int NUM_LINES = `MEMX_NUM_LINES;
	localparam int IDX_BITS = (NUM_LINES > 1) ? $clog2(NUM_LINES) : 1;
	localparam int WORDS = LINE_BITS / 32;

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_WRITE,
		ST_READ
	} state_e;

	state_e state;
	logic [IDX_BITS-1:0] line_idx;
	memx_pkg::test_mode_e mode_q;
	logic [31:0] seed_q;
	logic last_line;

	// Word w of line n is seed ^ {n, w}
	function automatic logic [LINE_BITS-1:0] line_data(input logic [31:0] s,
		input logic [IDX_BITS-1:0] n);
		logic [LINE_BITS-1:0] d;
		d = '0;
		for (int w = 0; w < WORDS; w++)
		begin
			d[w*32 +: 32] = s ^ {16'(n), 16'(w)};
		end
		return d;
	endfunction

	assign pass_start = start && (state == ST_IDLE);
	assign busy = (state != ST_IDLE);
	assign last_line = (line_idx == IDX_BITS'(NUM_LINES - 1));

	// Current command, held steady until the line counter moves
	assign cmd.write = (state == ST_WRITE);
	assign cmd.addr = `MEMX_BASE_ADDR
		+ ADDR_BITS'(line_idx) * ADDR_BITS'(`MEMX_ADDR_STRIDE);
	assign cmd.data = line_data(seed_q, line_idx);

	always_ff @(posedge clk)
	begin
		if (pass_start)
		begin
			mode_q <= mode;
			seed_q <= seed;
		end
	end

	////////////////////
	// Pass FSM
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			line_idx <= '0;
			cmd_valid <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (start)
					begin
						line_idx <= '0;
						// Read-only skips straight to the read phase
						state <= (mode == memx_pkg::MODE_READ_ONLY) ? ST_READ : ST_WRITE;
					end
				end
				default:
				begin
					if (!cmd_valid)
					begin
						cmd_valid <= 1'b1;
					end
					else if (rsp.ready)
					begin
						cmd_valid <= 1'b0;
						if (last_line)
						begin
							line_idx <= '0;
							if (state == ST_WRITE && mode_q == memx_pkg::MODE_WRITE_READ)
							begin
								state <= ST_READ;
							end
							else
							begin
								state <= ST_IDLE;
								done <= 1'b1;
							end
						end
						else
						begin
							line_idx <= line_idx + 1'b1;
						end
					end
				end
			endcase
		end
	end

endmodule

// ==== src/readback_checker.sv ====
`timescale 1ns/1ps
`include "memx_params.svh"

module readback_checker
(
	input logic clk,
	input logic rst,
	input logic pass_start,
	input memx_pkg::mem_cmd_t cmd,
	input memx_pkg::mem_rsp_t rsp,
	output logic [15:0] mismatch_count,
	output logic [`MEMX_ADDR_BITS-1:0] first_bad_addr,
	output logic any_mismatch
);

	logic rd_done;
	logic miss;

	// A read completes when ready rises with a read command up
	assign rd_done = rsp.ready && !cmd.write;

	// Full-line compare against the expected line on the command
	assign miss = rd_done && (rsp.data != cmd.data);

	assign any_mismatch = (mismatch_count != '0);

	////////////////////
	// Result registers
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst || pass_start)
		begin
			mismatch_count <= '0;
			first_bad_addr <= '0;
		end
		else if (miss)
		begin
			// Only the first failure of the pass is kept
			if (!any_mismatch)
			begin
				first_bad_addr <= cmd.addr;
			end
			// Saturate instead of wrapping back to zero
			if (mismatch_count != '1)
			begin
				mismatch_count <= mismatch_count + 16'd1;
			end
		end
	end

endmodule

// ==== verif/mem_exercise_sva.sv ====
`timescale 1ns/1ps
`include "memx_params.svh"

module mem_exercise_sva
(
	input logic clk,
	input logic rst,
	input logic cmd_valid,
	input memx_pkg::mem_cmd_t cmd,
	input memx_pkg::mem_rsp_t rsp,
	input logic busy,
	input logic done
);

	int fail_count = 0;

	// Command held while the store has not answered
	cmd_hold: assert property (@(posedge clk) disable iff (rst)
		(cmd_valid && !rsp.ready) |=> $stable(cmd))
	else
	begin
		fail_count++;
		$error("cmd changed while cmd_valid was high and ready was low");
	end

	ready_needs_valid: assert property (@(posedge clk) disable iff (rst)
		rsp.ready |-> cmd_valid)
	else
	begin
		fail_count++;
		$error("rsp.ready was high without cmd_valid");
	end

	// Covers every reset cycle and the first cycle after it
	quiet_after_reset: assert property (@(posedge clk)
		rst |=> (!busy && !done))
	else
	begin
		fail_count++;
		$error("busy or done high during or right after reset");
	end

	done_ends_busy: assert property (@(posedge clk) disable iff (rst)
		done |-> $fell(busy))
	else
	begin
		fail_count++;
		$error("done pulsed without busy falling in the same cycle");
	end

endmodule

// ==== verif/mem_exercise_tb.sv ====
`timescale 1ns/1ps
`include "memx_params.svh"

module mem_exercise_tb;

	localparam int NUM_LINES = `MEMX_NUM_LINES;
	localparam int LINE_BITS = `MEMX_LINE_BITS;
	localparam int ADDR_BITS = `MEMX_ADDR_BITS;
	localparam int DONE_TIMEOUT = 400;
	// Longer than a full write-read pass
	localparam int PASS_CYCLES = 2 * NUM_LINES * (`MEMX_LATENCY + 2) + 8;

	logic clk;
	logic rst;
	logic start;
	memx_pkg::test_mode_e mode;
	logic [31:0] seed;
	logic busy;
	logic done;
	logic [15:0] mismatch_count;
	logic [ADDR_BITS-1:0] first_bad_addr;
	logic any_mismatch;

	// Model of what the store holds for each line of a pass
	logic [LINE_BITS-1:0] model_mem [0:NUM_LINES-1];

	// Prediction for the pass in flight
	int exp_count;
	logic [ADDR_BITS-1:0] exp_addr;

	int done_count = 0;
	int passes = 0;
	int checks = 0;
	int errors = 0;
	bit timed_out = 1'b0;

	mem_exercise_top dut
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.mode(mode),
		.seed(seed),
		.busy(busy),
		.done(done),
		.mismatch_count(mismatch_count),
		.first_bad_addr(first_bad_addr),
		.any_mismatch(any_mismatch)
	);

	bind mem_exercise_top mem_exercise_sva u_sva
	(
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.rsp(rsp),
		.busy(busy),
		.done(done)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////
	// Reference model
	////////////////////

	// Word w of line n is the seed XOR {n, w}
	function automatic logic [LINE_BITS-1:0] expected_line(input logic [31:0] s, input int n);
		logic [LINE_BITS-1:0] line;
		logic [31:0] tag;
		line = '0;
		for (int w = 0; w < LINE_BITS / 32; w++)
		begin
			tag = {n[15:0], w[15:0]};
			line[w*32 +: 32] = s ^ tag;
		end
		return line;
	endfunction

	// Update the memory model and predict count and first bad address
	function automatic void predict_pass(input memx_pkg::test_mode_e m, input logic [31:0] s);
		exp_count = 0;
		exp_addr = '0;
		if (m != memx_pkg::MODE_READ_ONLY)
		begin
			for (int n = 0; n < NUM_LINES; n++)
				model_mem[n] = expected_line(s, n);
		end
		if (m != memx_pkg::MODE_WRITE_ONLY)
		begin
			for (int n = 0; n < NUM_LINES; n++)
			begin
				if (model_mem[n] != expected_line(s, n))
				begin
					if (exp_count == 0)
						exp_addr = ADDR_BITS'(`MEMX_BASE_ADDR + n * `MEMX_ADDR_STRIDE);
					exp_count++;
				end
			end
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	// Results are final while done is high
	always @(negedge clk)
	begin
		if (!rst && done)
		begin
			done_count++;
			check_value("mismatch_count", 32'(exp_count), 32'(mismatch_count));
			check_value("first_bad_addr", 32'(exp_addr), 32'(first_bad_addr));
			check_value("any_mismatch", 32'(exp_count != 0), 32'(any_mismatch));
			check_value("busy", 32'(0), 32'(busy));
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	task automatic finish_run();
		int sva_fails;
		sva_fails = dut.u_sva.fail_count;
		$display("Passes: %0d, checks: %0d, check errors: %0d, assertion failures: %0d",
			passes, checks, errors, sva_fails);
		if (errors == 0 && sva_fails == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	endtask

	task automatic pulse_start(input memx_pkg::test_mode_e m, input logic [31:0] s);
		@(posedge clk);
		start <= 1'b1;
		mode <= m;
		seed <= s;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_for_done();
		int cycles;
		cycles = 0;
		while (done !== 1'b1 && cycles < DONE_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (done !== 1'b1)
		begin
			errors++;
			timed_out = 1'b1;
			$display("Timed out after %0d cycles waiting for done", DONE_TIMEOUT);
		end
		else
		begin
			@(posedge clk);
		end
	endtask

	// An extra start mid-pass must be ignored
	task automatic run_pass(input memx_pkg::test_mode_e m, input logic [31:0] s,
		input bit extra_start);
		int dones_before;
		predict_pass(m, s);
		if (timed_out)
			return;
		dones_before = done_count;
		passes++;
		pulse_start(m, s);
		if (extra_start)
		begin
			repeat (3) @(negedge clk);
			check_value("busy", 32'(1), 32'(busy));
			pulse_start(memx_pkg::MODE_READ_ONLY, ~s);
		end
		wait_for_done();
		if (extra_start && !timed_out)
		begin
			// Room for a wrongly accepted pass to run to its end
			repeat (PASS_CYCLES) @(negedge clk);
			check_value("busy", 32'(0), 32'(busy));
			check_value("done pulses", 32'(1), 32'(done_count - dones_before));
		end
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			check_value("busy", 32'(0), 32'(busy));
			check_value("done", 32'(0), 32'(done));
			check_value("mismatch_count", 32'(0), 32'(mismatch_count));
			check_value("first_bad_addr", 32'(0), 32'(first_bad_addr));
			check_value("any_mismatch", 32'(0), 32'(any_mismatch));
		end
	endtask

	initial
	begin
		logic [31:0] seed_a;
		logic [31:0] seed_b;
		memx_pkg::test_mode_e m;
		void'($urandom(32'ha3fc_8496));
		rst = 1'b1;
		start = 1'b0;
		mode = memx_pkg::MODE_WRITE_READ;
		seed = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		// Quiet until the first start
		check_idle(8);

		run_pass(memx_pkg::MODE_WRITE_READ, $urandom(), 1'b0);

		// Same seed for write and read back
		seed_a = $urandom();
		run_pass(memx_pkg::MODE_WRITE_ONLY, seed_a, 1'b0);
		run_pass(memx_pkg::MODE_READ_ONLY, seed_a, 1'b0);

		// Any nonzero seed difference touches every word
		seed_b = seed_a ^ 32'h0040_8001;
		run_pass(memx_pkg::MODE_WRITE_ONLY, seed_a, 1'b0);
		run_pass(memx_pkg::MODE_READ_ONLY, seed_b, 1'b0);
		check_value("predicted count", 32'(NUM_LINES), 32'(exp_count));
		check_value("predicted address", 32'(`MEMX_BASE_ADDR), 32'(exp_addr));

		run_pass(memx_pkg::MODE_WRITE_READ, $urandom(), 1'b1);

		///////////////////
		// Back-to-back random passes
		///////////////////
		for (int k = 0; k < 8; k++)
		begin
			m = memx_pkg::test_mode_e'(2'($urandom_range(2, 0)));
			run_pass(m, $urandom(), 1'b0);
		end

		finish_run();
	end

endmodule

// ==== vlog.f ====
+incdir+src
src/memx_pkg.sv
src/pattern_sequencer.sv
src/line_store.sv
src/readback_checker.sv
src/mem_exercise_top.sv
verif/mem_exercise_sva.sv
verif/mem_exercise_tb.sv
